// File: hw/color_track_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed 80x60 frame with 12-bit rgb444 pixels, no runtime resize
// inner frame and bin width must stay consistent (64 cols / 8 bins)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef COLOR_TRACK_CONSTS_SVH
`define COLOR_TRACK_CONSTS_SVH

`define IMG_COLS       80    // frame width in pixels
`define IMG_ROWS       60
`define IMG_PXLS       4800  // cols * rows
`define ADDR_W         13    // enough for 0..4799
`define COL_W          7
`define ROW_W          6
`define INNER_COL_MIN  8     // 8 columns trimmed at each side
`define INNER_COL_MAX  71
`define INNER_ROW_MIN  6     // 6 rows trimmed top and bottom
`define INNER_ROW_MAX  53
`define HIST_BINS      8
`define BIN_W          3
`define BIN_COLS_LOG2  3     // 8 columns per bin
`define HIST_VAL_W     9     // 48 rows * 8 cols = 384 max per bin
`define SUM_W          12    // whole inner frame, 3072 max
`define PXL_W          12
`define MSB_RED        11    // top bit of each 4-bit colour
`define MSB_GREEN      7
`define MSB_BLUE       3
`define MIN_COLOR_PXLS 32    // at or below this, treated as noise
`define CENTROID_W     8     // one led per bit

`endif

// File: hw/color_track_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mode encodings are the r,g,b enable bits, do not renumber
// group sums are one bit narrower than the total
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "color_track_consts.svh"

package color_track_pkg;

  // colour selection, bit 2 red, bit 1 green, bit 0 blue
  typedef enum logic [2:0] {
    MODE_ALL     = 3'b000, // no filter, every pixel passes
    MODE_RED     = 3'b100,
    MODE_GREEN   = 3'b010,
    MODE_BLUE    = 3'b001,
    MODE_YELLOW  = 3'b110, // red and green
    MODE_MAGENTA = 3'b101, // red and blue
    MODE_CYAN    = 3'b011, // green and blue
    MODE_WHITE   = 3'b111
  } color_mode_t;

  // position info aligned with the pixel on orig_pxl
  typedef struct packed {
    logic              frame_end; // last address of the frame issued
    logic              inner;     // pixel inside the inner frame
    logic [`BIN_W-1:0] bin;       // histogram column bin
  } scan_pos_t;

  // running counts for the current frame
  typedef struct packed {
    logic [`SUM_W-1:0]      total;
    logic [`SUM_W-2:0]      left;     // bins 0..3
    logic [`SUM_W-2:0]      right;    // bins 4..7
    logic [`SUM_W-2:0]      bins_01;
    logic [`SUM_W-2:0]      bins_012;
    logic [`SUM_W-2:0]      bins_67;
    logic [`SUM_W-2:0]      bins_567;
    logic [`HIST_VAL_W-1:0] edge_0;   // bin 0 alone
    logic [`HIST_VAL_W-1:0] edge_7;   // bin 7 alone
  } hist_sums_t;

endpackage

// File: hw/frame_scanner.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free running, one address per clock, never stalls
// memory must return the pixel exactly one cycle after orig_addr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "color_track_consts.svh"

module frame_scanner (
  input  logic                     clk,
  input  logic                     rst,
  output logic [`ADDR_W-1:0]       orig_addr,
  output color_track_pkg::scan_pos_t pos
);

  logic [`ADDR_W-1:0] cnt_pxl;   // address of the pixel being requested
  logic [`COL_W-1:0]  col;       // column of cnt_pxl
  logic [`COL_W-1:0]  col_rg;    // column of the pixel now arriving
  logic [`ROW_W-1:0]  row;
  logic [`COL_W-1:0]  col_inner; // column relative to inner frame
  logic               end_pxl;
  logic               end_ln;

  assign end_pxl = (cnt_pxl == `ADDR_W'(`IMG_PXLS - 1));
  assign end_ln  = (col == `COL_W'(`IMG_COLS - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_pxl <= '0;
      col     <= '0;
      col_rg  <= '0;
      row     <= '0;
    end else begin
      cnt_pxl <= end_pxl ? '0 : cnt_pxl + 1'b1; // wrap 4799 -> 0
      col     <= end_ln ? '0 : col + 1'b1;
      col_rg  <= col;                            // follows memory latency
      if (end_pxl)
        row <= '0;
      else if (end_ln)
        row <= row + 1'b1;
    end
  end

  // row is not delayed, col_rg = 79 is outside the inner frame anyway
  assign col_inner = col_rg - `COL_W'(`INNER_COL_MIN);

  assign orig_addr     = cnt_pxl;
  assign pos.frame_end = end_pxl;
  assign pos.inner     = (col_rg >= `COL_W'(`INNER_COL_MIN)) &&
                         (col_rg <= `COL_W'(`INNER_COL_MAX)) &&
                         (row >= `ROW_W'(`INNER_ROW_MIN)) &&
                         (row <= `ROW_W'(`INNER_ROW_MAX));
  assign pos.bin       = col_inner[`BIN_COLS_LOG2 +: `BIN_W]; // 8 cols per bin

  // counters must never leave the frame, else bins alias
  a_pos_in_frame: assert property (
    @(posedge clk) disable iff (rst)
    (col < `COL_W'(`IMG_COLS)) && (row < `ROW_W'(`IMG_ROWS))
  ) else $error("scan position out of frame col=%0d row=%0d", col, row);

endmodule

// File: hw/color_mode_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// proc_ctrl is a raw button level, no debounce here
// a held button is one press, mode moves 3 clocks after the edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "color_track_consts.svh"

module color_mode_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        proc_ctrl,
  input  logic [`PXL_W-1:0]           orig_pxl,
  output color_track_pkg::color_mode_t rgbfilter,
  output logic                        color_hit
);

  import color_track_pkg::*;

  logic       btn_meta;  // first sync stage
  logic       btn_sync;
  logic       btn_prev;  // for edge detection
  logic       btn_rise;
  logic [2:0] pxl_msbs;  // r,g,b top bits of the pixel

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      btn_meta <= 1'b0;
      btn_sync <= 1'b0;
      btn_prev <= 1'b0;
    end else begin
      btn_meta <= proc_ctrl;
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;
    end
  end

  assign btn_rise = btn_sync & ~btn_prev;

  // step through the modes on each press
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rgbfilter <= MODE_ALL;
    end else if (btn_rise) begin
      case (rgbfilter)
        MODE_ALL:     rgbfilter <= MODE_RED;
        MODE_RED:     rgbfilter <= MODE_GREEN;
        MODE_GREEN:   rgbfilter <= MODE_BLUE;
        MODE_BLUE:    rgbfilter <= MODE_YELLOW;
        MODE_YELLOW:  rgbfilter <= MODE_MAGENTA;
        MODE_MAGENTA: rgbfilter <= MODE_CYAN;
        MODE_CYAN:    rgbfilter <= MODE_WHITE;
        default:      rgbfilter <= MODE_ALL; // white wraps around
      endcase
    end
  end

  assign pxl_msbs  = {orig_pxl[`MSB_RED], orig_pxl[`MSB_GREEN], orig_pxl[`MSB_BLUE]};
  // exact match of msbs against mode bits, mode all lets everything through
  assign color_hit = (rgbfilter == MODE_ALL) || (pxl_msbs == rgbfilter);

  a_mode_on_press: assert property (
    @(posedge clk) disable iff (rst)
    $changed(rgbfilter) |-> $past(btn_rise)
  ) else $error("rgbfilter changed without a button edge");

endmodule

// File: hw/bin_histogram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// counts are valid for one frame and clear at frame_end
// only group sums leave the block, single bins stay inside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "color_track_consts.svh"

module bin_histogram (
  input  logic                        clk,
  input  logic                        rst,
  input  color_track_pkg::scan_pos_t  pos,
  input  logic                        color_hit,
  output color_track_pkg::hist_sums_t sums
);

  logic [`HIST_VAL_W-1:0] hist [`HIST_BINS]; // per-bin pixel counts
  logic [`SUM_W-1:0]      total;
  logic [`SUM_W-2:0]      left;
  logic [`SUM_W-2:0]      right;
  logic [`SUM_W-2:0]      bins_01;
  logic [`SUM_W-2:0]      bins_012;
  logic [`SUM_W-2:0]      bins_67;
  logic [`SUM_W-2:0]      bins_567;
  logic                   count_en;

  assign count_en = pos.inner & color_hit;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `HIST_BINS; i++)
        hist[i] <= '0;
      total    <= '0;
      left     <= '0;
      right    <= '0;
      bins_01  <= '0;
      bins_012 <= '0;
      bins_67  <= '0;
      bins_567 <= '0;
    end else if (pos.frame_end) begin // new frame starts clean
      for (int i = 0; i < `HIST_BINS; i++)
        hist[i] <= '0;
      total    <= '0;
      left     <= '0;
      right    <= '0;
      bins_01  <= '0;
      bins_012 <= '0;
      bins_67  <= '0;
      bins_567 <= '0;
    end else if (count_en) begin
      hist[pos.bin] <= hist[pos.bin] + 1'b1;
      total         <= total + 1'b1;
      // bump every group the bin belongs to
      if (pos.bin <= `BIN_W'(3))
        left <= left + 1'b1;
      else
        right <= right + 1'b1;
      if (pos.bin <= `BIN_W'(1)) bins_01  <= bins_01 + 1'b1;
      if (pos.bin <= `BIN_W'(2)) bins_012 <= bins_012 + 1'b1;
      if (pos.bin >= `BIN_W'(6)) bins_67  <= bins_67 + 1'b1;
      if (pos.bin >= `BIN_W'(5)) bins_567 <= bins_567 + 1'b1;
    end
  end

  assign sums.total    = total;
  assign sums.left     = left;
  assign sums.right    = right;
  assign sums.bins_01  = bins_01;
  assign sums.bins_012 = bins_012;
  assign sums.bins_67  = bins_67;
  assign sums.bins_567 = bins_567;
  assign sums.edge_0   = hist[0];
  assign sums.edge_7   = hist[`HIST_BINS-1];

  // both halves together must account for every counted pixel
  a_halves_sum: assert property (
    @(posedge clk) disable iff (rst)
    ({1'b0, sums.left} + sums.right) == sums.total
  ) else $error("left+right != total (%0d)", sums.total);

endmodule

// File: hw/centroid_decide.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// centroid is a led pattern, one or two bits set, not a number
// it updates once per frame, new_centroid is a 1-cycle strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "color_track_consts.svh"

module centroid_decide (
  input  logic                        clk,
  input  logic                        rst,
  input  color_track_pkg::scan_pos_t  pos,
  input  color_track_pkg::hist_sums_t sums,
  output logic [`CENTROID_W-1:0]      centroid,
  output logic                        new_centroid
);

  logic                   left_more; // more hits left of centre
  logic [`SUM_W-2:0]      abs_diff;
  logic [`SUM_W-2:0]      half;      // total / 2
  logic [`SUM_W-2:0]      sixteenth; // total / 16, centre tolerance
  logic [`CENTROID_W-1:0] pattern;

  assign left_more = sums.left > sums.right;
  assign abs_diff  = left_more ? (sums.left - sums.right) : (sums.right - sums.left);
  assign half      = sums.total[`SUM_W-1:1];
  assign sixteenth = {3'b000, sums.total[`SUM_W-1:4]}; // widened back to SUM_W-1

  // start from the edges and move inwards
  always_comb begin
    pattern = '0;
    if (sums.total <= `SUM_W'(`MIN_COLOR_PXLS)) begin
      pattern = '0;                // too few hits, likely noise
    end else if (abs_diff < sixteenth) begin
      pattern[4:3] = 2'b11;        // roughly centred
    end else if (left_more) begin
      if (sums.edge_0 >= half)        pattern[0] = 1'b1;
      else if (sums.bins_01 >= half)  pattern[1] = 1'b1;
      else if (sums.bins_012 >= half) pattern[2] = 1'b1;
      else if (sums.left > half)      pattern[3] = 1'b1;
    end else begin                 // mirror of the left side
      if (sums.edge_7 >= half)        pattern[7] = 1'b1;
      else if (sums.bins_67 >= half)  pattern[6] = 1'b1;
      else if (sums.bins_567 >= half) pattern[5] = 1'b1;
      else if (sums.right > half)     pattern[4] = 1'b1;
    end
  end

  // sample at the last address, sums still hold the full frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      centroid     <= '0;
      new_centroid <= 1'b0;
    end else begin
      new_centroid <= pos.frame_end;
      if (pos.frame_end)
        centroid <= pattern;
    end
  end

endmodule

// File: hw/color_track_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame memory sits outside, read latency must be one clock
// first new_centroid comes 4800 clocks after reset release
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "color_track_consts.svh"

module color_track_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        proc_ctrl,  // colour select button
  input  logic [`PXL_W-1:0]           orig_pxl,
  output logic [`ADDR_W-1:0]          orig_addr,
  output logic [`CENTROID_W-1:0]      centroid,
  output logic                        new_centroid,
  output color_track_pkg::color_mode_t rgbfilter
);

  import color_track_pkg::*;

  scan_pos_t  pos;       // scanner position, aligned to orig_pxl
  hist_sums_t sums;
  logic       color_hit; // pixel passes the colour filter

  frame_scanner u_scanner (
    .clk       (clk),
    .rst       (rst),
    .orig_addr (orig_addr),
    .pos       (pos)
  );

  color_mode_ctrl u_mode (
    .clk       (clk),
    .rst       (rst),
    .proc_ctrl (proc_ctrl),
    .orig_pxl  (orig_pxl),
    .rgbfilter (rgbfilter),
    .color_hit (color_hit)
  );

  bin_histogram u_hist (
    .clk       (clk),
    .rst       (rst),
    .pos       (pos),
    .color_hit (color_hit),
    .sums      (sums)
  );

  centroid_decide u_centroid (
    .clk          (clk),
    .rst          (rst),
    .pos          (pos),
    .sums         (sums),
    .centroid     (centroid),
    .new_centroid (new_centroid)
  );

endmodule

// File: tb/color_track_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame buffer model answers in the cycle after orig_addr
// each centroid check waits two strobes, frame during the fill is mixed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "color_track_consts.svh"

module color_track_tb;

  import color_track_pkg::*;

  localparam int     FRAMES_USED = 24; // 2 for scan test, 2 per centroid check, spare
  localparam longint TIMEOUT_NS  = FRAMES_USED * `IMG_PXLS * 10 + 20000;

  logic                   clk;
  logic                   rst;
  logic                   proc_ctrl;
  logic [`PXL_W-1:0]      orig_pxl;
  logic [`ADDR_W-1:0]     orig_addr;
  logic [`CENTROID_W-1:0] centroid;
  logic                   new_centroid;
  color_mode_t            rgbfilter;

  logic [`PXL_W-1:0]  frame_mem [`IMG_PXLS]; // frame buffer contents
  logic [`ADDR_W-1:0] addr_q;                 // address seen one cycle ago
  integer             seed;
  int                 errors;

  color_track_top dut (
    .clk          (clk),
    .rst          (rst),
    .proc_ctrl    (proc_ctrl),
    .orig_pxl     (orig_pxl),
    .orig_addr    (orig_addr),
    .centroid     (centroid),
    .new_centroid (new_centroid),
    .rgbfilter    (rgbfilter)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  // pixel of address A is driven mid-cycle, in the cycle after A
  always @(negedge clk) begin
    addr_q   <= orig_addr;
    orig_pxl <= frame_mem[addr_q];
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("Something failed");
    $fatal(1, "timeout");
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Something failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // returns at the negedge where new_centroid is high
  task automatic wait_strobe();
    int n;
    n = 0;
    @(negedge clk);
    while (new_centroid !== 1'b1) begin
      n++;
      if (n > `IMG_PXLS + 16) begin
        errors++;
        $display("no new_centroid strobe seen within one frame");
        $display("Something failed");
        $fatal(1, "strobe missing");
      end
      @(negedge clk);
    end
  endtask

  // random shade that keeps the three colour msbs
  function automatic logic [`PXL_W-1:0] shade(input logic [2:0] msbs);
    logic [31:0] rv;
    rv = $random(seed);
    return {msbs[2], rv[2:0], msbs[1], rv[5:3], msbs[0], rv[8:6]};
  endfunction

  task automatic clear_frame();
    for (int a = 0; a < `IMG_PXLS; a++)
      frame_mem[a] = '0; // black
  endtask

  task automatic paint_block(input int col_lo, input int col_hi, input int row_lo,
                             input int row_hi, input logic [2:0] msbs);
    for (int r = row_lo; r <= row_hi; r++)
      for (int c = col_lo; c <= col_hi; c++)
        frame_mem[r * `IMG_COLS + c] = shade(msbs);
  endtask

  task automatic expect_centroid(input string name, input logic [7:0] exp);
    wait_strobe();
    wait_strobe(); // this frame was read fully after the fill
    check(name, centroid, exp);
  endtask

  task automatic press_button();
    proc_ctrl = 1'b1;
    repeat (4) @(negedge clk);
    proc_ctrl = 1'b0;
    repeat (6) @(negedge clk);
  endtask

  task automatic set_mode(input color_mode_t target);
    int presses;
    presses = 0;
    while (rgbfilter != target) begin
      if (presses == 8) begin
        errors++;
        $display("colour mode never reached the requested value");
        $display("Something failed");
        $fatal(1, "mode stuck");
      end
      press_button();
      presses++;
    end
  endtask

  // mode order ALL RED GREEN BLUE YELLOW MAGENTA CYAN WHITE
  function automatic color_mode_t mode_after(input int presses);
    case (presses % 8)
      1:       return MODE_RED;
      2:       return MODE_GREEN;
      3:       return MODE_BLUE;
      4:       return MODE_YELLOW;
      5:       return MODE_MAGENTA;
      6:       return MODE_CYAN;
      7:       return MODE_WHITE;
      default: return MODE_ALL;
    endcase
  endfunction

  task automatic test_reset_and_scan();
    check("rgbfilter", rgbfilter, MODE_ALL);
    check("centroid", centroid, 0);
    check("new_centroid", new_centroid, 0);
    // address steps every cycle, strobe exactly every frame
    for (int n = 1; n <= 2 * `IMG_PXLS; n++) begin
      @(negedge clk);
      check("orig_addr", orig_addr, n % `IMG_PXLS);
      check("new_centroid", new_centroid, (n % `IMG_PXLS) == 0);
    end
  endtask

  task automatic test_mode_stepping();
    for (int p = 1; p <= 8; p++) begin
      press_button();
      check("rgbfilter", rgbfilter, mode_after(p));
    end
  endtask

  task automatic test_black_and_noise();
    logic [31:0] rv;
    clear_frame();
    expect_centroid("centroid black all", 8'h18); // whole inner frame, centred
    set_mode(MODE_RED);
    expect_centroid("centroid black red", 8'h00);
    for (int k = 0; k < 20; k++) begin
      rv = $random(seed);
      frame_mem[(`INNER_ROW_MIN + rv[11:6] % 48) * `IMG_COLS
                + `INNER_COL_MIN + rv[5:0]] = shade(3'b100);
    end
    expect_centroid("centroid red noise", 8'h00); // below noise minimum
  endtask

  task automatic test_red_blocks();
    set_mode(MODE_RED);
    clear_frame();
    paint_block(8, 15, `INNER_ROW_MIN, `INNER_ROW_MAX, 3'b100);
    expect_centroid("centroid red bin0", 8'h01);
    clear_frame();
    paint_block(64, 71, `INNER_ROW_MIN, `INNER_ROW_MAX, 3'b100);
    expect_centroid("centroid red bin7", 8'h80);
    clear_frame();
    paint_block(32, 39, `INNER_ROW_MIN, `INNER_ROW_MAX, 3'b100);
    expect_centroid("centroid red bin3", 8'h08);
  endtask

  task automatic test_cyan_select();
    set_mode(MODE_GREEN);
    clear_frame();
    paint_block(8, 15, `INNER_ROW_MIN, `INNER_ROW_MAX, 3'b011);
    expect_centroid("centroid cyan under green", 8'h00);
    set_mode(MODE_CYAN);
    expect_centroid("centroid cyan under cyan", 8'h01);
    clear_frame();
    paint_block(0, 7, 0, `IMG_ROWS - 1, 3'b011); // left border only
    expect_centroid("centroid cyan outside", 8'h00);
  endtask

  initial begin
    seed      = 46900;
    errors    = 0;
    rst       = 1'b1;
    proc_ctrl = 1'b0;
    orig_pxl  = '0;
    addr_q    = '0;
    clear_frame();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    test_reset_and_scan();
    test_mode_stepping();
    test_black_and_noise();
    test_red_blocks();
    test_cyan_select();
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: src.f
+incdir+hw
hw/color_track_pkg.sv
hw/frame_scanner.sv
hw/color_mode_ctrl.sv
hw/bin_histogram.sv
hw/centroid_decide.sv
hw/color_track_top.sv
tb/color_track_tb.sv

// File: Bender.yml
package:
  name: color_track

sources:
  - include_dirs:
      - hw
    files:
      - hw/color_track_pkg.sv
      - hw/frame_scanner.sv
      - hw/color_mode_ctrl.sv
      - hw/bin_histogram.sv
      - hw/centroid_decide.sv
      - hw/color_track_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tb/color_track_tb.sv
